// ==== board_game_top.sv ====
`default_nettype none

module board_game_top #(
    parameter int tick_cycles = 100_000_000
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             start_btn,
    input  logic                             dice_valid,
    input  logic [game_pkg::dice_width-1:0]  dice_value,
    input  logic                             turn_done,
    output logic [game_pkg::pos_width-1:0]   p1_pos,
    output logic [game_pkg::pos_width-1:0]   p2_pos,
    output logic                             pos_valid,
    output logic                             turn,
    output logic                             winner_valid,
    output logic                             winner_id,
    output logic [game_pkg::pos_width-1:0]   event_flag,
    output logic [15:0]                      led_output,
    output logic [3:0]                       fnd_com,
    output logic [7:0]                       fnd_data
);

    logic                           move_en;
    logic                           knock_en;
    logic                           timer_clear;
    logic                           timer_run;
    logic                           timed_out;
    display_pkg::led_mode_t         led_mode;
    logic [game_pkg::pos_width-1:0] square_kind;
    logic [game_pkg::pos_width-1:0] mover_pos;  // feeds the display

    game_fsm u_fsm (
        .clk          (clk),
        .reset        (reset),
        .start_btn    (start_btn),
        .dice_valid   (dice_valid),
        .turn_done    (turn_done),
        .square_kind  (square_kind),
        .timed_out    (timed_out),
        .move_en      (move_en),
        .knock_en     (knock_en),
        .timer_clear  (timer_clear),
        .timer_run    (timer_run),
        .led_mode     (led_mode),
        .turn         (turn),
        .pos_valid    (pos_valid),
        .winner_valid (winner_valid),
        .winner_id    (winner_id),
        .event_flag   (event_flag)
    );

    position_unit u_pos (
        .clk         (clk),
        .reset       (reset),
        .move_en     (move_en),
        .knock_en    (knock_en),
        .turn        (turn),
        .dice_value  (dice_value),
        .p1_pos      (p1_pos),
        .p2_pos      (p2_pos),
        .mover_pos   (mover_pos),
        .square_kind (square_kind)
    );

    turn_timer #(
        .tick_cycles (tick_cycles)
    ) u_timer (
        .clk         (clk),
        .reset       (reset),
        .turn        (turn),
        .timer_clear (timer_clear),
        .timer_run   (timer_run),
        .led_mode    (led_mode),
        .timed_out   (timed_out),
        .led_output  (led_output)
    );

    fnd_controller u_fnd (
        .clk       (clk),
        .reset     (reset),
        .mover_pos (mover_pos),
        .fnd_com   (fnd_com),
        .fnd_data  (fnd_data)
    );

endmodule

`default_nettype wire

// ==== display_pkg.sv ====
`default_nettype none

package display_pkg;

    // led bar patterns, 16 leds
    localparam logic [15:0] led_all_on  = 16'hffff;  // idle
    localparam logic [15:0] led_p1_turn = 16'hff00;  // player 1 owns upper byte
    localparam logic [15:0] led_p2_turn = 16'h00ff;  // player 2 owns lower byte
    localparam logic [15:0] led_p1_win  = 16'hf0f0;
    localparam logic [15:0] led_p2_win  = 16'h0f0f;

    // which pattern a timer clear loads
    typedef enum logic [1:0] {
        led_idle,
        led_turn,
        led_win
    } led_mode_t;

    // digit scan, about 1 ms per digit at 100 MHz
    localparam int scan_cycles = 100_000;

    // segments active low, bit 7 is dp (kept off)
    localparam logic [7:0] seg_blank = 8'hff;
    localparam logic [7:0] seg_table [10] = '{
        8'hc0, 8'hf9, 8'ha4, 8'hb0, 8'h99,  // 0..4
        8'h92, 8'h82, 8'hf8, 8'h80, 8'h90   // 5..9
    };

endpackage

`default_nettype wire

// ==== fnd_controller.sv ====
`default_nettype none

module fnd_controller (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [game_pkg::pos_width-1:0] mover_pos,
    output logic [3:0]                     fnd_com,   // active low digit enables
    output logic [7:0]                     fnd_data   // active low segments
);

    logic [$clog2(display_pkg::scan_cycles)-1:0] scan_cnt;
    logic [1:0]                                  digit_sel;  // 0 = rightmost
    logic [game_pkg::pos_width-1:0]              tens;
    logic [game_pkg::pos_width-1:0]              ones;

    // 0..10 only, so tens is 0 or 1
    assign tens = mover_pos / 4'd10;
    assign ones = mover_pos % 4'd10;

    // digit rotation
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            scan_cnt  <= '0;
            digit_sel <= '0;
        end else if (scan_cnt == display_pkg::scan_cycles - 1) begin
            scan_cnt  <= '0;
            digit_sel <= digit_sel + 1'b1;  // wraps after digit 3
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    always_comb begin
        case (digit_sel)
            2'd0: begin
                fnd_com  = 4'b1110;
                fnd_data = display_pkg::seg_table[ones];
            end
            2'd1: begin
                fnd_com  = 4'b1101;
                fnd_data = display_pkg::seg_table[tens];
            end
            2'd2: begin
                fnd_com  = 4'b1011;
                fnd_data = display_pkg::seg_blank;  // unused digit
            end
            default: begin
                fnd_com  = 4'b0111;
                fnd_data = display_pkg::seg_blank;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== game_fsm.sv ====
`default_nettype none

module game_fsm (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             start_btn,
    input  logic                             dice_valid,   // one-cycle strobe
    input  logic                             turn_done,    // ui finished the event
    input  logic [game_pkg::pos_width-1:0]   square_kind,  // class of mover's square
    input  logic                             timed_out,
    output logic                             move_en,
    output logic                             knock_en,
    output logic                             timer_clear,
    output logic                             timer_run,
    output display_pkg::led_mode_t           led_mode,
    output logic                             turn,         // 0 = player 1
    output logic                             pos_valid,
    output logic                             winner_valid,
    output logic                             winner_id,
    output logic [game_pkg::pos_width-1:0]   event_flag
);

    game_pkg::game_state_t state;
    game_pkg::game_state_t next_state;
    logic                  turn_flip;  // toggle turn on this edge
    logic                  is_win;

    assign is_win = (square_kind == game_pkg::evt_win);

    // state and turn bit
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= game_pkg::idle;
            turn  <= 1'b0;  // player 1 opens
        end else begin
            state <= next_state;
            if (turn_flip) begin
                turn <= ~turn;  // lands together with entry to next_turn
            end
        end
    end

    always_comb begin
        next_state  = state;
        turn_flip   = 1'b0;
        move_en     = 1'b0;
        knock_en    = 1'b0;
        timer_clear = 1'b0;
        timer_run   = 1'b0;
        led_mode    = display_pkg::led_turn;
        case (state)
            game_pkg::idle: begin
                timer_clear = 1'b1;  // counters parked, leds follow led_mode
                if (start_btn) begin
                    next_state = game_pkg::wait_dice;  // load player 1 pattern
                end else begin
                    led_mode = display_pkg::led_idle;
                end
            end
            game_pkg::wait_dice: begin
                timer_run = 1'b1;
                if (dice_valid) begin
                    timer_clear = 1'b1;  // refill the countdown
                    next_state  = game_pkg::update_pos;
                end else if (timed_out) begin
                    turn_flip  = 1'b1;  // no dice, other player
                    next_state = game_pkg::next_turn;
                end
            end
            game_pkg::update_pos: begin
                move_en    = 1'b1;
                next_state = game_pkg::check_event;
            end
            game_pkg::check_event: begin
                if (is_win) begin
                    timer_clear = 1'b1;
                    led_mode    = display_pkg::led_win;  // win pattern of the mover
                    next_state  = game_pkg::win;
                end else begin
                    knock_en   = (square_kind == game_pkg::evt_knockback);
                    next_state = game_pkg::start_event;
                end
            end
            game_pkg::start_event: begin
                // plain and knockback squares pass straight through
                if (event_flag == game_pkg::evt_none ||
                    event_flag == game_pkg::evt_knockback ||
                    turn_done) begin
                    turn_flip  = 1'b1;
                    next_state = game_pkg::next_turn;
                end
            end
            game_pkg::next_turn: begin
                timer_clear = 1'b1;  // pattern of the new mover
                next_state  = game_pkg::wait_dice;
            end
            game_pkg::win: begin
                led_mode = display_pkg::led_win;  // hold forever
            end
            default: begin
                next_state = game_pkg::idle;
            end
        endcase
    end

    // status outputs
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pos_valid    <= 1'b0;
            winner_valid <= 1'b0;
            winner_id    <= 1'b0;
            event_flag   <= game_pkg::evt_none;
        end else begin
            case (state)
                game_pkg::update_pos: begin
                    pos_valid <= 1'b1;  // new position visible next cycle
                end
                game_pkg::check_event: begin
                    event_flag <= square_kind;  // win code is 10
                    if (is_win) begin
                        winner_valid <= 1'b1;
                        winner_id    <= turn;
                    end
                end
                game_pkg::start_event: begin
                    pos_valid <= 1'b0;
                end
                default: begin
                end
            endcase
        end
    end

    // the position unit must never see both commands in one cycle
    assert property (@(posedge clk) disable iff (reset) !(move_en && knock_en))
        else $error("move_en and knock_en high together");

    // a declared winner stays declared
    assert property (@(posedge clk) disable iff (reset) winner_valid |=> winner_valid)
        else $error("winner_valid fell before reset");

endmodule

`default_nettype wire

// ==== game_input.txt ====
# action operand p1_pos p2_pos event_flag turn winner
# turn 0 = player 1, winner 0 = none, 1 or 2 = that player
check   0 0 0 0 0 0
start   0 0 0 0 0 0
dice    1 1 0 0 1 0
dice    2 1 2 2 1 0
done    0 1 2 2 0 0
dice    2 0 2 3 1 0
timeout 0 0 2 3 0 0
dice    1 1 2 0 1 0
dice    3 1 5 0 0 0
dice    3 4 5 4 0 0
done    0 4 5 4 1 0
dice    1 4 6 6 1 0
done    0 4 6 6 0 0
timeout 0 4 6 6 1 0
dice    2 4 8 8 1 0
done    0 4 8 8 0 0
dice    3 7 8 0 1 0
# player 2 overshoots from 8 and is capped at 10
dice    3 7 10 10 1 2
dice    1 7 10 10 1 2
done    0 7 10 10 1 2
check   0 7 10 10 1 2

// ==== game_pkg.sv ====
`default_nettype none

package game_pkg;

    // position width first, the square constants below are sized by it
    localparam int pos_width  = 4;  // squares 0..10
    localparam int dice_width = 2;  // dice comes in as 1..3

    localparam logic [pos_width-1:0] board_last = 4'd10;  // finish square, moves cap here

    // turn passes after this many second ticks without a dice
    localparam int timeout_ticks = 8;

    // event flag codes
    localparam logic [pos_width-1:0] evt_none      = 4'd0;
    localparam logic [pos_width-1:0] evt_knockback = 4'd3;   // square 3, back to start
    localparam logic [pos_width-1:0] evt_win       = 4'd10;  // reached board_last

    // one bit per square, set on the event squares 2, 4, 6 and 8
    // an event square reports its own number as the flag code
    localparam logic [2**pos_width-1:0] event_square_mask = 16'h0154;

    // turn sequence
    typedef enum logic [2:0] {
        idle,         // waiting for start
        wait_dice,    // timer running, dice expected
        update_pos,   // apply dice to mover
        check_event,  // classify new square
        start_event,  // hold for ui on event squares
        next_turn,    // turn bit already flipped here
        win           // parked until reset
    } game_state_t;

endpackage

`default_nettype wire

// ==== position_unit.sv ====
`default_nettype none

module position_unit (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             move_en,   // add dice to mover
    input  logic                             knock_en,  // mover back to 0
    input  logic                             turn,
    input  logic [game_pkg::dice_width-1:0]  dice_value,
    output logic [game_pkg::pos_width-1:0]   p1_pos,
    output logic [game_pkg::pos_width-1:0]   p2_pos,
    output logic [game_pkg::pos_width-1:0]   mover_pos,
    output logic [game_pkg::pos_width-1:0]   square_kind
);

    logic [game_pkg::dice_width-1:0] dice_q;  // dice as it was with the strobe
    logic [game_pkg::pos_width:0]    sum;     // spare bit for carry
    logic [game_pkg::pos_width-1:0]  capped;

    // update_pos comes one cycle after the strobe
    always_ff @(posedge clk) begin
        dice_q <= dice_value;
    end

    assign mover_pos = turn ? p2_pos : p1_pos;

    assign sum = {1'b0, mover_pos}
               + {{(game_pkg::pos_width + 1 - game_pkg::dice_width){1'b0}}, dice_q};
    assign capped = (sum >= game_pkg::board_last) ? game_pkg::board_last
                                                   : sum[game_pkg::pos_width-1:0];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            p1_pos <= '0;
            p2_pos <= '0;
        end else if (knock_en) begin
            if (turn) begin
                p2_pos <= '0;
            end else begin
                p1_pos <= '0;
            end
        end else if (move_en) begin
            if (turn) begin
                p2_pos <= capped;
            end else begin
                p1_pos <= capped;
            end
        end
    end

    // only the mover's square counts
    always_comb begin
        if (mover_pos >= game_pkg::board_last) begin
            square_kind = game_pkg::evt_win;
        end else if (mover_pos == game_pkg::evt_knockback) begin
            square_kind = game_pkg::evt_knockback;
        end else if (game_pkg::event_square_mask[mover_pos]) begin
            square_kind = mover_pos;  // event code = square number
        end else begin
            square_kind = game_pkg::evt_none;
        end
    end

    // capping holds across move and knockback sequences
    assert property (@(posedge clk) disable iff (reset)
        (p1_pos <= game_pkg::board_last) && (p2_pos <= game_pkg::board_last))
        else $error("position beyond last square");

endmodule

`default_nettype wire

// ==== tb.f ====
game_pkg.sv
display_pkg.sv
game_fsm.sv
position_unit.sv
turn_timer.sv
fnd_controller.sv
board_game_top.sv
tb_board_game.sv

// ==== tb_board_game.sv ====
`default_nettype none

module tb_board_game;

    localparam int tick_cycles = 4;   // fast second tick
    localparam int max_steps   = 64;
    localparam int last_square = 10;  // finish square
    localparam int wait_cycles = game_pkg::timeout_ticks * tick_cycles;
    localparam int step_cycles = wait_cycles + 20;  // watchdog budget per scenario line

    logic        clk;
    logic        reset;
    logic        start_btn;
    logic        dice_valid;
    logic [1:0]  dice_value;
    logic        turn_done;
    logic [3:0]  p1_pos;
    logic [3:0]  p2_pos;
    logic        pos_valid;
    logic        turn;
    logic        winner_valid;
    logic        winner_id;
    logic [3:0]  event_flag;
    logic [15:0] led_output;
    logic [3:0]  fnd_com;
    logic [7:0]  fnd_data;

    // scenario table
    logic [8*8-1:0] act_q [max_steps];   // action word, right aligned
    int             op_q  [max_steps];
    int             exp_q [max_steps][5];  // p1, p2, flag, turn, winner
    int             n_steps;
    bit             steps_loaded;

    // reference model
    int pos_m [2];
    int flag_m;
    int turn_m;     // 0 = player 1
    int winner_m;   // 0 none, else player number
    bit started_m;
    bit hold_m;     // on an event square, waiting for turn_done
    int errors;

    board_game_top #(
        .tick_cycles (tick_cycles)
    ) u_dut (
        .clk          (clk),
        .reset        (reset),
        .start_btn    (start_btn),
        .dice_valid   (dice_valid),
        .dice_value   (dice_value),
        .turn_done    (turn_done),
        .p1_pos       (p1_pos),
        .p2_pos       (p2_pos),
        .pos_valid    (pos_valid),
        .turn         (turn),
        .winner_valid (winner_valid),
        .winner_id    (winner_id),
        .event_flag   (event_flag),
        .led_output   (led_output),
        .fnd_com      (fnd_com),
        .fnd_data     (fnd_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp) else begin
            $display("ERROR time=%0t %s: got %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic expect_rule(input bit ok, input string what);
        assert (ok) else begin
            $display("%s (time %0t)", what, $time);
            errors++;
        end
    endtask

    // countdown pattern at the start of a turn, player 0 or 1
    function automatic logic [15:0] turn_leds(input int player);
        return player ? display_pkg::led_p2_turn : display_pkg::led_p1_turn;
    endfunction

    function automatic logic [15:0] win_leds(input int player);
        return player ? display_pkg::led_p2_win : display_pkg::led_p1_win;
    endfunction

    task automatic start_game();
        @(posedge clk);
        start_btn <= 1'b1;
        @(posedge clk);
        start_btn <= 1'b0;
        @(negedge clk);
        started_m = 1'b1;
        check_value("led_output", led_output, turn_leds(0));  // player 1 opens
    endtask

    task automatic play_dice(input int value);
        int mover;
        int cycles;
        mover = turn_m;
        if (winner_m == 0) begin
            check_value("pos_valid", pos_valid, 1'b0);  // low between turns
        end
        @(posedge clk);
        dice_valid <= 1'b1;
        dice_value <= value[1:0];
        @(posedge clk);
        dice_valid <= 1'b0;
        if (winner_m != 0) begin
            repeat (3) @(posedge clk);  // game over, strobe changes nothing
            @(negedge clk);
            check_value("led_output", led_output, win_leds(winner_m - 1));
        end else begin
            cycles = 1;
            @(negedge clk);
            while (!pos_valid && cycles < 8) begin
                @(posedge clk);
                cycles++;
                @(negedge clk);
            end
            expect_rule(pos_valid, "pos_valid never rose after the dice strobe");
            check_value("pos_valid delay", cycles, 2);
            pos_m[mover] = pos_m[mover] + value;
            if (pos_m[mover] > last_square) begin
                pos_m[mover] = last_square;  // capped at the finish
            end
            check_value("p1_pos", p1_pos, pos_m[0]);  // before any knockback
            check_value("p2_pos", p2_pos, pos_m[1]);
            if (pos_m[mover] == last_square) begin
                flag_m   = last_square;
                winner_m = mover + 1;
            end else if (pos_m[mover] == 3) begin
                flag_m       = 3;  // knockback
                pos_m[mover] = 0;
                turn_m       = 1 - mover;
            end else if (pos_m[mover] % 2 == 0) begin
                flag_m = pos_m[mover];  // squares 2, 4, 6, 8
                hold_m = 1'b1;
            end else begin
                flag_m = 0;
                turn_m = 1 - mover;
            end
            repeat (2) @(posedge clk);  // flag lands, then the turn decision
            @(negedge clk);
            if (winner_m != 0) begin
                check_value("led_output", led_output, win_leds(mover));
            end else if (!hold_m) begin
                @(posedge clk);  // countdown reload for the new mover
                @(negedge clk);
                check_value("led_output", led_output, turn_leds(turn_m));
            end
        end
    endtask

    task automatic press_done();
        @(posedge clk);
        turn_done <= 1'b1;
        @(posedge clk);
        turn_done <= 1'b0;
        @(negedge clk);
        if (hold_m) begin
            hold_m = 1'b0;
            turn_m = 1 - turn_m;
            @(posedge clk);
            @(negedge clk);
            check_value("led_output", led_output, turn_leds(turn_m));
        end
    endtask

    task automatic wait_timeout();
        int cycles;
        cycles = 0;
        if (winner_m != 0) begin
            repeat (wait_cycles + 4) @(posedge clk);  // parked, nothing may move
            @(negedge clk);
        end else begin
            while (turn === turn_m && cycles < wait_cycles + 4) begin
                @(posedge clk);
                cycles++;
                @(negedge clk);
                if (cycles == tick_cycles) begin
                    // one tick in, the mover's half lost its inner led
                    check_value("led_output", led_output, turn_m ? 16'h007f : 16'hfe00);
                end
            end
            expect_rule(turn !== turn_m, "turn did not pass after the dice timeout");
            check_value("timeout cycles", cycles, wait_cycles + 1);
            check_value("led_output", led_output, 16'h0000);  // half fully shifted out
            turn_m = 1 - turn_m;
            @(posedge clk);
            @(negedge clk);
            check_value("led_output", led_output, turn_leds(turn_m));
        end
    endtask

    task automatic compare_step(input int i);
        int mover_sq;  // square of the player whose turn it is
        mover_sq = (exp_q[i][3] != 0) ? exp_q[i][1] : exp_q[i][0];
        expect_rule(pos_m[0] == exp_q[i][0] && pos_m[1] == exp_q[i][1] &&
                    flag_m == exp_q[i][2] && turn_m == exp_q[i][3] &&
                    winner_m == exp_q[i][4],
                    "scenario line disagrees with the game rules");
        check_value("p1_pos", p1_pos, exp_q[i][0]);
        check_value("p2_pos", p2_pos, exp_q[i][1]);
        check_value("event_flag", event_flag, exp_q[i][2]);
        check_value("turn", turn, exp_q[i][3]);
        check_value("winner_valid", winner_valid, exp_q[i][4] != 0);
        if (exp_q[i][4] != 0) begin
            check_value("winner_id", winner_id, exp_q[i][4] - 1);
        end
        // short run, scan never leaves the ones digit
        check_value("fnd_com", fnd_com, 4'b1110);
        check_value("fnd_data", fnd_data, display_pkg::seg_table[mover_sq % 10]);
    endtask

    initial begin
        int             fd;
        int             code;
        int             i;
        int             first_err;
        int             failed;
        string          label;
        logic [8*8-1:0] act;
        logic [8*80-1:0] rest;
        reset      <= 1'b1;
        start_btn  <= 1'b0;
        dice_valid <= 1'b0;
        dice_value <= 2'd0;
        turn_done  <= 1'b0;
        pos_m[0]  = 0;
        pos_m[1]  = 0;
        flag_m    = 0;
        turn_m    = 0;
        winner_m  = 0;
        started_m = 1'b0;
        hold_m    = 1'b0;
        errors    = 0;
        failed    = 0;
        n_steps   = 0;
        fd = $fopen("game_input.txt", "r");
        if (fd == 0) begin
            $display("could not open game_input.txt");
            errors++;
        end else begin
            while ($fscanf(fd, "%s", act) == 1) begin
                if (act == "#") begin
                    code = $fgets(rest, fd);  // rest of a comment line
                end else if (n_steps < max_steps) begin
                    act_q[n_steps] = act;
                    code = $fscanf(fd, "%d %d %d %d %d %d", op_q[n_steps],
                                   exp_q[n_steps][0], exp_q[n_steps][1],
                                   exp_q[n_steps][2], exp_q[n_steps][3], exp_q[n_steps][4]);
                    expect_rule(code == 6, "scenario line has missing fields");
                    n_steps++;
                end
            end
            $fclose(fd);
        end
        steps_loaded = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        for (i = 0; i < n_steps; i++) begin
            first_err = errors;
            if (act_q[i] == "start") begin
                label = "start";
                start_game();
            end else if (act_q[i] == "dice") begin
                label = "dice";
                play_dice(op_q[i]);
            end else if (act_q[i] == "done") begin
                label = "done";
                press_done();
            end else if (act_q[i] == "timeout") begin
                label = "timeout";
                wait_timeout();
            end else if (act_q[i] == "check") begin
                label = "check";
                if (!started_m) begin
                    check_value("led_output", led_output, display_pkg::led_all_on);
                    check_value("pos_valid", pos_valid, 1'b0);
                end
            end else begin
                label = "unknown";
                expect_rule(1'b0, "unknown action word in game_input.txt");
            end
            compare_step(i);
            if (errors == first_err) begin
                $display("step %0d %s: pass", i + 1, label);
            end else begin
                $display("step %0d %s: fail", i + 1, label);
                failed++;
            end
        end
        $display("steps %0d, passed %0d, failed %0d, errors %0d",
                 n_steps, n_steps - failed, failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // watchdog, sized from the scenario length
    initial begin
        wait (steps_loaded);
        repeat (n_steps * step_cycles + 4) @(posedge clk);
        $display("watchdog expired, scenario still running after %0d cycles",
                 n_steps * step_cycles + 4);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== turn_timer.sv ====
`default_nettype none

module turn_timer #(
    parameter int tick_cycles = 100_000_000  // clocks per second tick
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   turn,
    input  logic                   timer_clear,  // restart and reload leds
    input  logic                   timer_run,    // high in wait_dice
    input  display_pkg::led_mode_t led_mode,
    output logic                   timed_out,
    output logic [15:0]            led_output
);

    logic [31:0]                                    prescale;
    logic [$clog2(game_pkg::timeout_ticks + 1)-1:0] elapsed;  // whole ticks so far
    logic                                           tick;
    logic [15:0]                                    load_pattern;

    // counting freezes once the limit is reached
    assign tick      = timer_run && !timed_out && (prescale == tick_cycles - 1);
    assign timed_out = (elapsed == game_pkg::timeout_ticks);

    always_comb begin
        case (led_mode)
            display_pkg::led_turn: begin
                load_pattern = turn ? display_pkg::led_p2_turn : display_pkg::led_p1_turn;
            end
            display_pkg::led_win: begin
                load_pattern = turn ? display_pkg::led_p2_win : display_pkg::led_p1_win;
            end
            default: begin
                load_pattern = display_pkg::led_all_on;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prescale   <= '0;
            elapsed    <= '0;
            led_output <= display_pkg::led_all_on;
        end else if (timer_clear) begin
            prescale   <= '0;
            elapsed    <= '0;
            led_output <= load_pattern;
        end else if (timer_run && !timed_out) begin
            if (tick) begin
                prescale <= '0;
                elapsed  <= elapsed + 1'b1;
                // halves empty away from the middle, p1 up, p2 down
                if (turn) begin
                    led_output <= (led_output >> 1) & display_pkg::led_p2_turn;
                end else begin
                    led_output <= (led_output << 1) & display_pkg::led_p1_turn;
                end
            end else begin
                prescale <= prescale + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire
